// File: files.f
+incdir+design
design/vga_pkg.sv
design/crtc_regs.sv
design/video_timing.sv
design/pixel_fetch.sv
design/color_lookup.sv
design/vga_display.sv
sim/vga_display_chk.sv
sim/vga_display_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := vga_display_tb
FILELIST   := files.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := *** FAILED ***
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation stopped early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/vga_display_tb.sv
`include "vga_macros.svh"

module vga_display_tb;

  import vga_pkg::*;

  localparam int HALF_PERIOD  = 20;
  localparam int DRIVE_DLY    = 2;
  localparam int FRAME_CYCLES = 24 * 10;
  localparam int NUM_TESTS    = 6;
  // Two frames per test, plus reset and table loads
  localparam int CYCLE_LIMIT  = NUM_TESTS * 2 * FRAME_CYCLES + 600;

  logic        clk;
  logic        rst;
  logic        reg_we;
  reg_addr_t   reg_addr;
  count_t      reg_wdata;
  logic        mem_stb;
  mem_addr_t   mem_adr;
  mem_word_t   mem_dat;
  logic        pal_we;
  attr_t       pal_addr;
  dac_index_t  pal_wdata;
  dac_index_t  pal_rdata;
  logic        dac_we;
  dac_index_t  dac_addr;
  rgb6_t       dac_wdata;
  rgb6_t       dac_rdata;
  rgb4_t       rgb;
  logic        hsync;
  logic        vsync;
  logic        v_retrace;
  logic        vh_retrace;

  mem_word_t   vmem [0:65535];
  dac_index_t  pal_model [0:15];
  rgb6_t       dac_model [0:255];
  crt_timing_t mode;
  int          seed = 19;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          pad_h;
  int          pad_v;
  logic        rd_pend = 1'b0;
  mem_addr_t   rd_adr;

  vga_display i_dut (
    .clk          (clk),
    .rst          (rst),
    .reg_we_i     (reg_we),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .mem_stb_o    (mem_stb),
    .mem_adr_o    (mem_adr),
    .mem_dat_i    (mem_dat),
    .pal_we_i     (pal_we),
    .pal_addr_i   (pal_addr),
    .pal_wdata_i  (pal_wdata),
    .pal_rdata_o  (pal_rdata),
    .dac_we_i     (dac_we),
    .dac_addr_i   (dac_addr),
    .dac_wdata_i  (dac_wdata),
    .dac_rdata_o  (dac_rdata),
    .rgb_o        (rgb),
    .hsync_o      (hsync),
    .vsync_o      (vsync),
    .v_retrace_o  (v_retrace),
    .vh_retrace_o (vh_retrace)
  );

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  // Video memory, data valid for the whole cycle after the strobe
  always @(posedge clk)
  begin
    #DRIVE_DLY;
    if (rd_pend)
      mem_dat = vmem[rd_adr];
    else
      mem_dat = 'x;
    rd_pend = mem_stb;
    rd_adr  = mem_adr;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  function automatic mem_word_t random_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic dac_index_t random_index();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic rgb6_t random_rgb6();
    logic [31:0] r;
    r = $random(seed);
    return r[17:0];
  endfunction

  task automatic check_rgb(input string what, input rgb4_t got, input rgb4_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rgb6(input string what, input rgb6_t got, input rgb6_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_index(input string what, input dac_index_t got,
                             input dac_index_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at time %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input count_t got, input count_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at time %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input mem_addr_t got, input mem_addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  task automatic write_reg(input reg_addr_t addr, input count_t data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    step();
    reg_we = 1'b0;
  endtask

  task automatic write_palette(input attr_t addr, input dac_index_t data);
    pal_we          = 1'b1;
    pal_addr        = addr;
    pal_wdata       = data;
    pal_model[addr] = data;
    step();
    pal_we = 1'b0;
  endtask

  task automatic write_dac(input dac_index_t addr, input rgb6_t data);
    dac_we          = 1'b1;
    dac_addr        = addr;
    dac_wdata       = data;
    dac_model[addr] = data;
    step();
    dac_we = 1'b0;
  endtask

  // Small mode, 24 cycles per line and 10 lines per frame
  task automatic program_mode();
    mode.h_total      = 10'd23;
    mode.h_disp_end   = 10'd15;
    mode.h_sync_start = 10'd18;
    mode.h_sync_end   = 10'd20;
    mode.v_total      = 10'd9;
    mode.v_disp_end   = 10'd5;
    mode.v_sync_start = 10'd7;
    mode.v_sync_end   = 10'd8;
    write_reg(`REG_H_TOTAL, mode.h_total);
    write_reg(`REG_H_DISP_END, mode.h_disp_end);
    write_reg(`REG_H_SYNC_START, mode.h_sync_start);
    write_reg(`REG_H_SYNC_END, mode.h_sync_end);
    write_reg(`REG_V_TOTAL, mode.v_total);
    write_reg(`REG_V_DISP_END, mode.v_disp_end);
    write_reg(`REG_V_SYNC_START, mode.v_sync_start);
    write_reg(`REG_V_SYNC_END, mode.v_sync_end);
  endtask

  task automatic advance_pos(inout int h, inout int v);
    if (h == int'(mode.h_total))
    begin
      h = 0;
      v = (v == int'(mode.v_total)) ? 0 : v + 1;
    end
    else
      h = h + 1;
  endtask

  function automatic logic sync_level(input bit use_vsync);
    return use_vsync ? vsync : hsync;
  endfunction

  // Lands on the pad cycle that shows the first hsync fall of the vsync window
  task automatic sync_to_frame();
    while (vsync !== 1'b1)
      step();
    while (vsync !== 1'b0)
      step();
    while (hsync !== 1'b0)
      step();
    pad_h = int'(mode.h_sync_start);
    pad_v = int'(mode.v_sync_start);
  endtask

  task automatic measure_pulse(input bit use_vsync, output int low, output int period);
    low = 0;
    while (sync_level(use_vsync) !== 1'b1)
      step();
    while (sync_level(use_vsync) !== 1'b0)
      step();
    while (sync_level(use_vsync) === 1'b0)
    begin
      low++;
      step();
    end
    period = low;
    while (sync_level(use_vsync) === 1'b1)
    begin
      period++;
      step();
    end
  endtask

  // Pixel expected at the pads for a visible beam position
  function automatic rgb4_t expected_pixel(input int h, input int v);
    int        words;
    mem_word_t word;
    attr_t     nib;
    rgb6_t     c;
    rgb4_t     p;
    words   = (int'(mode.h_disp_end) + 1) / 4;
    word    = vmem[16'(v * words + h / 4)];
    nib     = word[4 * (h % 4) +: 4];
    c       = dac_model[pal_model[nib]];
    p.red   = c.red[5:2];
    p.green = c.green[5:2];
    p.blue  = c.blue[5:2];
    return p;
  endfunction

  task automatic test_reset();
    int e0;
    e0 = errors;
    rst = 1'b1;
    repeat (4) step();
    check_rgb("rgb in reset", rgb, '0);
    check_bit("hsync in reset", hsync, 1'b1);
    check_bit("vsync in reset", vsync, 1'b1);
    check_bit("mem_stb in reset", mem_stb, 1'b0);
    rst = 1'b0;
    report_test("reset", e0);
  endtask

  task automatic test_tables();
    dac_index_t idx [0:15];
    int         e0;
    int         k;
    e0 = errors;
    for (k = 0; k < 16; k++)
      write_palette(attr_t'(k), random_index());
    for (k = 0; k < 16; k++)
    begin
      idx[k] = random_index();
      write_dac(idx[k], random_rgb6());
    end
    for (k = 0; k < 16; k++)
    begin
      pal_addr = attr_t'(k);
      step();
      check_index($sformatf("palette %0d", k), pal_rdata, pal_model[k]);
    end
    for (k = 0; k < 16; k++)
    begin
      dac_addr = idx[k];
      step();
      check_rgb6($sformatf("dac %0d", idx[k]), dac_rdata, dac_model[idx[k]]);
    end
    report_test("tables", e0);
  endtask

  task automatic test_sync_widths();
    int e0;
    int low;
    int period;
    int line_len;
    e0 = errors;
    line_len = int'(mode.h_total) + 1;
    measure_pulse(1'b0, low, period);
    check_count("hsync low width", count_t'(low), mode.h_sync_end - mode.h_sync_start + 1'b1);
    check_count("hsync period", count_t'(period), count_t'(line_len));
    measure_pulse(1'b1, low, period);
    check_count("vsync low width", count_t'(low),
                count_t'((int'(mode.v_sync_end) - int'(mode.v_sync_start) + 1) * line_len));
    check_count("vsync period", count_t'(period),
                count_t'((int'(mode.v_total) + 1) * line_len));
    report_test("sync", e0);
  endtask

  task automatic test_pixels();
    int e0;
    int k;
    e0 = errors;
    // Every palette output needs a defined DAC entry
    for (k = 0; k < 16; k++)
      write_dac(pal_model[k], random_rgb6());
    sync_to_frame();
    for (k = 0; k < FRAME_CYCLES; k++)
    begin
      if (pad_h <= int'(mode.h_disp_end) && pad_v <= int'(mode.v_disp_end))
        check_rgb($sformatf("pixel %0d,%0d", pad_h, pad_v), rgb,
                  expected_pixel(pad_h, pad_v));
      step();
      advance_pos(pad_h, pad_v);
    end
    report_test("pixels", e0);
  endtask

  task automatic test_blanking();
    int   e0;
    int   k;
    int   bh;
    int   bv;
    logic v_out;
    logic h_out;
    e0 = errors;
    sync_to_frame();
    // Retrace flags have no delay, so the beam runs three cycles ahead of the pads
    bh = pad_h;
    bv = pad_v;
    repeat (3) advance_pos(bh, bv);
    for (k = 0; k < FRAME_CYCLES; k++)
    begin
      if (pad_h > int'(mode.h_disp_end) || pad_v > int'(mode.v_disp_end))
        check_rgb($sformatf("blank %0d,%0d", pad_h, pad_v), rgb, '0);
      v_out = (bv > int'(mode.v_disp_end));
      h_out = (bh > int'(mode.h_disp_end));
      check_bit($sformatf("v_retrace %0d,%0d", bh, bv), v_retrace, v_out);
      check_bit($sformatf("vh_retrace %0d,%0d", bh, bv), vh_retrace, v_out | h_out);
      step();
      advance_pos(pad_h, pad_v);
      advance_pos(bh, bv);
    end
    report_test("blanking", e0);
  endtask

  task automatic test_narrow_line();
    int e0;
    int k;
    int line;
    int line_len;
    int words;
    int strobes [0:5];
    e0 = errors;
    while (v_retrace !== 1'b1)
      step();
    mode.h_disp_end = 10'd11;
    write_reg(`REG_H_DISP_END, mode.h_disp_end);
    line_len = int'(mode.h_total) + 1;
    words    = (int'(mode.h_disp_end) + 1) / 4;
    for (k = 0; k < 6; k++)
      strobes[k] = 0;
    // Beam is at the first pixel of the frame once v_retrace drops
    while (v_retrace !== 1'b0)
      step();
    for (k = 0; k < 6 * line_len; k++)
    begin
      line = k / line_len;
      if (mem_stb === 1'b1)
      begin
        check_addr($sformatf("read address line %0d", line), mem_adr,
                   mem_addr_t'(line * words + strobes[line]));
        strobes[line]++;
      end
      step();
    end
    for (k = 0; k < 6; k++)
      check_count($sformatf("reads in line %0d", k), count_t'(strobes[k]), count_t'(words));
    report_test("narrow", e0);
  endtask

  initial
  begin
    rst       = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    mem_dat   = '0;
    pal_we    = 1'b0;
    pal_addr  = '0;
    pal_wdata = '0;
    dac_we    = 1'b0;
    dac_addr  = '0;
    dac_wdata = '0;
    for (int i = 0; i < 65536; i++)
      vmem[i] = random_word();
    test_reset();
    program_mode();
    test_tables();
    test_sync_widths();
    test_pixels();
    test_blanking();
    test_narrow_line();
    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: sim/vga_display_chk.sv
module vga_display_chk (
  input logic           clk,
  input logic           rst,
  input logic           mem_stb_i,
  input logic           vh_retrace_i,
  input vga_pkg::rgb4_t rgb_i
);

  import vga_pkg::*;

  // Reads start only while the beam is in the display region
  stb_outside_retrace: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_stb_i) |-> !vh_retrace_i)
    else $error("memory strobe raised during retrace");

  // One read per group of four pixels
  stb_single_cycle: assert property (@(posedge clk) disable iff (rst)
    mem_stb_i |=> !mem_stb_i)
    else $error("memory strobe high on two consecutive cycles");

  // Three cycles of pipeline behind the beam
  blank_after_retrace: assert property (@(posedge clk) disable iff (rst)
    vh_retrace_i && $past(vh_retrace_i) && $past(vh_retrace_i, 2) |=> rgb_i == '0)
    else $error("colour output not blank after retrace");

endmodule

bind vga_display vga_display_chk i_chk (
  .clk          (clk),
  .rst          (rst),
  .mem_stb_i    (mem_stb_o),
  .vh_retrace_i (vh_retrace_o),
  .rgb_i        (rgb_o)
);

// File: design/vga_display.sv
module vga_display (
  input  logic                clk,
  input  logic                rst,
  input  logic                reg_we_i,
  input  vga_pkg::reg_addr_t  reg_addr_i,
  input  vga_pkg::count_t     reg_wdata_i,
  output logic                mem_stb_o,
  output vga_pkg::mem_addr_t  mem_adr_o,
  input  vga_pkg::mem_word_t  mem_dat_i,
  input  logic                pal_we_i,
  input  vga_pkg::attr_t      pal_addr_i,
  input  vga_pkg::dac_index_t pal_wdata_i,
  output vga_pkg::dac_index_t pal_rdata_o,
  input  logic                dac_we_i,
  input  vga_pkg::dac_index_t dac_addr_i,
  input  vga_pkg::rgb6_t      dac_wdata_i,
  output vga_pkg::rgb6_t      dac_rdata_o,
  output vga_pkg::rgb4_t      rgb_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                v_retrace_o,
  output logic                vh_retrace_o
);

  import vga_pkg::*;

  crt_timing_t timing;
  beam_pos_t   beam;
  attr_t       attr;
  logic        video_on;
  logic        hsync_raw;
  logic        vsync_raw;
  logic        hsync_dly;
  logic        vsync_dly;

  crtc_regs i_regs (
    .clk         (clk),
    .rst         (rst),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .timing_o    (timing)
  );

  video_timing i_timing (
    .clk          (clk),
    .rst          (rst),
    .timing_i     (timing),
    .beam_o       (beam),
    .hsync_o      (hsync_raw),
    .vsync_o      (vsync_raw),
    .v_retrace_o  (v_retrace_o),
    .vh_retrace_o (vh_retrace_o)
  );

  pixel_fetch i_fetch (
    .clk        (clk),
    .rst        (rst),
    .timing_i   (timing),
    .beam_i     (beam),
    .hsync_i    (hsync_raw),
    .vsync_i    (vsync_raw),
    .mem_stb_o  (mem_stb_o),
    .mem_adr_o  (mem_adr_o),
    .mem_dat_i  (mem_dat_i),
    .attr_o     (attr),
    .video_on_o (video_on),
    .hsync_o    (hsync_dly),
    .vsync_o    (vsync_dly)
  );

  color_lookup i_color (
    .clk         (clk),
    .rst         (rst),
    .attr_i      (attr),
    .video_on_i  (video_on),
    .hsync_i     (hsync_dly),
    .vsync_i     (vsync_dly),
    .pal_we_i    (pal_we_i),
    .pal_addr_i  (pal_addr_i),
    .pal_wdata_i (pal_wdata_i),
    .pal_rdata_o (pal_rdata_o),
    .dac_we_i    (dac_we_i),
    .dac_addr_i  (dac_addr_i),
    .dac_wdata_i (dac_wdata_i),
    .dac_rdata_o (dac_rdata_o),
    .rgb_o       (rgb_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o)
  );

endmodule

// File: design/color_lookup.sv
`include "vga_macros.svh"

module color_lookup (
  input  logic                clk,
  input  logic                rst,
  input  vga_pkg::attr_t      attr_i,
  input  logic                video_on_i,
  input  logic                hsync_i,
  input  logic                vsync_i,
  input  logic                pal_we_i,
  input  vga_pkg::attr_t      pal_addr_i,
  input  vga_pkg::dac_index_t pal_wdata_i,
  output vga_pkg::dac_index_t pal_rdata_o,
  input  logic                dac_we_i,
  input  vga_pkg::dac_index_t dac_addr_i,
  input  vga_pkg::rgb6_t      dac_wdata_i,
  output vga_pkg::rgb6_t      dac_rdata_o,
  output vga_pkg::rgb4_t      rgb_o,
  output logic                hsync_o,
  output logic                vsync_o
);

  import vga_pkg::*;

  dac_index_t pal_mem [0:(1<<`ATTR_W)-1];
  rgb6_t      dac_mem [0:(1<<`INDEX_W)-1];
  dac_index_t index;
  rgb6_t      color;

  // Host writes
  always_ff @(posedge clk)
  begin
    if (pal_we_i)
      pal_mem[pal_addr_i] <= pal_wdata_i;
    if (dac_we_i)
      dac_mem[dac_addr_i] <= dac_wdata_i;
  end

  // Read-back straight from the address
  assign pal_rdata_o = pal_mem[pal_addr_i];
  assign dac_rdata_o = dac_mem[dac_addr_i];

  // Attribute -> palette -> DAC, all in one cycle
  assign index = pal_mem[attr_i];
  assign color = dac_mem[index];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rgb_o   <= '0;
      hsync_o <= 1'b1;
      vsync_o <= 1'b1;
    end
    else
    begin
      if (video_on_i)
      begin
        // Top four bits of each six-bit channel
        rgb_o.red   <= color.red[`DAC_CH_W-1 -: 4];
        rgb_o.green <= color.green[`DAC_CH_W-1 -: 4];
        rgb_o.blue  <= color.blue[`DAC_CH_W-1 -: 4];
      end
      else
        rgb_o <= '0;
      hsync_o <= hsync_i;
      vsync_o <= vsync_i;
    end
  end

endmodule

// File: design/pixel_fetch.sv
`include "vga_macros.svh"

module pixel_fetch (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_pkg::crt_timing_t timing_i,
  input  vga_pkg::beam_pos_t   beam_i,
  input  logic                 hsync_i,
  input  logic                 vsync_i,
  output logic                 mem_stb_o,
  output vga_pkg::mem_addr_t   mem_adr_o,
  input  vga_pkg::mem_word_t   mem_dat_i,
  output vga_pkg::attr_t       attr_o,
  output logic                 video_on_o,
  output logic                 hsync_o,
  output logic                 vsync_o
);

  import vga_pkg::*;

  mem_addr_t line_base;
  count_t    line_words;
  logic      fetch;
  logic      line_end;
  logic      frame_end;
  logic      stb_q;
  logic [1:0] sel_q1;
  logic [1:0] sel_q2;
  logic [1:0] on_q;
  logic [1:0] hs_q;
  logic [1:0] vs_q;
  mem_word_t word_hold;
  mem_word_t word_sel;

  // Four pixels per word
  assign line_words = (timing_i.h_disp_end + 1'b1) >> 2;
  assign fetch      = beam_i.h_active && beam_i.v_active && (beam_i.h_count[1:0] == 2'b00);
  assign line_end   = beam_i.v_active && (beam_i.h_count == timing_i.h_disp_end);
  assign frame_end  = (beam_i.h_count == timing_i.h_total) &&
                      (beam_i.v_count == timing_i.v_total);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      line_base <= '0;
      mem_stb_o <= 1'b0;
      stb_q     <= 1'b0;
      on_q      <= 2'b00;
      hs_q      <= 2'b11;
      vs_q      <= 2'b11;
    end
    else
    begin
      if (frame_end)
        line_base <= '0;
      else if (line_end)
        line_base <= line_base + mem_addr_t'(line_words);
      mem_stb_o <= fetch;
      stb_q     <= mem_stb_o;
      on_q      <= {on_q[0], beam_i.h_active && beam_i.v_active};
      hs_q      <= {hs_q[0], hsync_i};
      vs_q      <= {vs_q[0], vsync_i};
    end
  end

  always_ff @(posedge clk)
  begin
    mem_adr_o <= line_base + mem_addr_t'(beam_i.h_count[`CNT_W-1:2]);
    sel_q1    <= beam_i.h_count[1:0];
    sel_q2    <= sel_q1;
    // Keep the word for the other three pixels of the group
    if (stb_q)
      word_hold <= mem_dat_i;
  end

  // Bus data is only valid in the cycle after the strobe
  assign word_sel = stb_q ? mem_dat_i : word_hold;
  assign attr_o   = word_sel[sel_q2*`ATTR_W +: `ATTR_W];

  assign video_on_o = on_q[1];
  assign hsync_o    = hs_q[1];
  assign vsync_o    = vs_q[1];

endmodule

// File: design/video_timing.sv
module video_timing (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_pkg::crt_timing_t timing_i,
  output vga_pkg::beam_pos_t   beam_o,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic                 v_retrace_o,
  output logic                 vh_retrace_o
);

  import vga_pkg::*;

  beam_pos_t beam_q;
  count_t    h_next;
  count_t    v_next;
  logic      h_wrap;
  logic      v_wrap;
  logic      hsync_q;
  logic      vsync_q;

  // >= so a shortened total after reprogramming still wraps at once
  assign h_wrap = (beam_q.h_count >= timing_i.h_total);
  assign v_wrap = (beam_q.v_count >= timing_i.v_total);

  always_comb
  begin
    h_next = h_wrap ? '0 : beam_q.h_count + 1'b1;
    v_next = beam_q.v_count;
    if (h_wrap)
    begin
      v_next = v_wrap ? '0 : beam_q.v_count + 1'b1;
    end
  end

  // Enables and syncs are taken from the next count, so they line up
  // with the registered beam position in the same cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      beam_q.h_count  <= '0;
      beam_q.v_count  <= '0;
      beam_q.h_active <= 1'b1;
      beam_q.v_active <= 1'b1;
      hsync_q         <= 1'b1;
      vsync_q         <= 1'b1;
    end
    else
    begin
      beam_q.h_count  <= h_next;
      beam_q.v_count  <= v_next;
      beam_q.h_active <= (h_next <= timing_i.h_disp_end);
      beam_q.v_active <= (v_next <= timing_i.v_disp_end);
      // Active low inside the sync window
      hsync_q <= !((h_next >= timing_i.h_sync_start) &&
                   (h_next <= timing_i.h_sync_end));
      vsync_q <= !((v_next >= timing_i.v_sync_start) &&
                   (v_next <= timing_i.v_sync_end));
    end
  end

  assign beam_o  = beam_q;
  assign hsync_o = hsync_q;
  assign vsync_o = vsync_q;

  // Retrace flags for the host, no pipeline delay
  assign v_retrace_o  = !beam_q.v_active;
  assign vh_retrace_o = v_retrace_o | !beam_q.h_active;

endmodule

// File: design/crtc_regs.sv
`include "vga_macros.svh"

module crtc_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 reg_we_i,
  input  vga_pkg::reg_addr_t   reg_addr_i,
  input  vga_pkg::count_t      reg_wdata_i,
  output vga_pkg::crt_timing_t timing_o
);

  import vga_pkg::*;

  crt_timing_t regs_q;

  // One register per address, new value visible after the next edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      regs_q.h_total      <= `DEF_H_TOTAL;
      regs_q.h_disp_end   <= `DEF_H_DISP_END;
      regs_q.h_sync_start <= `DEF_H_SYNC_START;
      regs_q.h_sync_end   <= `DEF_H_SYNC_END;
      regs_q.v_total      <= `DEF_V_TOTAL;
      regs_q.v_disp_end   <= `DEF_V_DISP_END;
      regs_q.v_sync_start <= `DEF_V_SYNC_START;
      regs_q.v_sync_end   <= `DEF_V_SYNC_END;
    end
    else if (reg_we_i)
    begin
      case (reg_addr_i)
        `REG_H_TOTAL:      regs_q.h_total      <= reg_wdata_i;
        `REG_H_DISP_END:   regs_q.h_disp_end   <= reg_wdata_i;
        `REG_H_SYNC_START: regs_q.h_sync_start <= reg_wdata_i;
        `REG_H_SYNC_END:   regs_q.h_sync_end   <= reg_wdata_i;
        `REG_V_TOTAL:      regs_q.v_total      <= reg_wdata_i;
        `REG_V_DISP_END:   regs_q.v_disp_end   <= reg_wdata_i;
        `REG_V_SYNC_START: regs_q.v_sync_start <= reg_wdata_i;
        `REG_V_SYNC_END:   regs_q.v_sync_end   <= reg_wdata_i;
      endcase
    end
  end

  assign timing_o = regs_q;

endmodule

// File: design/vga_pkg.sv
package vga_pkg;

  `include "vga_macros.svh"

  typedef logic [`CNT_W-1:0]      count_t;
  typedef logic [`ATTR_W-1:0]     attr_t;
  typedef logic [`INDEX_W-1:0]    dac_index_t;
  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0] mem_word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // One DAC table entry
  typedef struct packed {
    logic [`DAC_CH_W-1:0] red;
    logic [`DAC_CH_W-1:0] green;
    logic [`DAC_CH_W-1:0] blue;
  } rgb6_t;

  // Colour at the pads
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb4_t;

  // Same order as the register map
  typedef struct packed {
    count_t h_total;
    count_t h_disp_end;
    count_t h_sync_start;
    count_t h_sync_end;
    count_t v_total;
    count_t v_disp_end;
    count_t v_sync_start;
    count_t v_sync_end;
  } crt_timing_t;

  typedef struct packed {
    count_t h_count;
    count_t v_count;
    logic   h_active;
    logic   v_active;
  } beam_pos_t;

endpackage

// File: design/vga_macros.svh
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// Datapath widths
`define CNT_W      10
`define ATTR_W     4
`define INDEX_W    8
`define DAC_CH_W   6
`define MEM_ADDR_W 16
`define MEM_DATA_W 16
`define REG_ADDR_W 3

// CRTC register map
`define REG_H_TOTAL      3'd0
`define REG_H_DISP_END   3'd1
`define REG_H_SYNC_START 3'd2
`define REG_H_SYNC_END   3'd3
`define REG_V_TOTAL      3'd4
`define REG_V_DISP_END   3'd5
`define REG_V_SYNC_START 3'd6
`define REG_V_SYNC_END   3'd7

// 640x480 at 25 MHz pixel clock
`define DEF_H_TOTAL      10'd799
`define DEF_H_DISP_END   10'd639
`define DEF_H_SYNC_START 10'd655
`define DEF_H_SYNC_END   10'd750
`define DEF_V_TOTAL      10'd524
`define DEF_V_DISP_END   10'd479
`define DEF_V_SYNC_START 10'd489
`define DEF_V_SYNC_END   10'd490

`endif
